//--- Bender.yml
package:
  name: dct32_odd

sources:
  - rtl/dct_odd_pkg.sv
  - rtl/spiral_16.sv
  - rtl/odd_sample_sequencer.sv
  - rtl/odd_mac_bank.sv
  - rtl/coef_serializer.sv
  - rtl/dct32_odd_top.sv
  - target: test
    files:
      - verification/tb_dct32_odd.sv

//--- rtl/coef_serializer.sv
// Two result banks and a rounding shifter that stream one coefficient per
// transfer, rows in order, with back-pressure on the output
`timescale 1ns/1ps

module coef_serializer #(
  parameter int OUT_SHIFT = 4
) (
  input  logic                                        clk,
  input  logic                                        i_reset,
  input  logic                                        i_done,
  input  logic signed [dct_odd_pkg::ACC_W-1:0]          i_sums [dct_odd_pkg::NUM_ROWS],
  output logic                                        o_pending_full,
  output logic signed [dct_odd_pkg::ACC_W-OUT_SHIFT-1:0] o_coef,
  output logic [3:0]                                  o_coef_row,
  output logic                                        o_coef_valid,
  input  logic                                        i_coef_ready
);
  import dct_odd_pkg::*;

  localparam logic signed [ACC_W-1:0] ROUND = ACC_W'(1) <<< (OUT_SHIFT - 1);

  logic signed [ACC_W-1:0] pend [NUM_ROWS];
  logic signed [ACC_W-1:0] act  [NUM_ROWS];
  logic signed [ACC_W-1:0] rounded;
  logic                    pend_full;
  logic                    act_valid;
  logic [3:0]              row;
  logic                    xfer;
  logic                    act_free;

  assign xfer     = act_valid && i_coef_ready;
  assign act_free = !act_valid || (xfer && row == 4'(NUM_ROWS - 1));

  // A finished block skips the pending bank when active is free
  always_ff @(posedge clk) begin
    if (act_free && pend_full) begin
      act <= pend;
    end else if (act_free && i_done) begin
      act <= i_sums;
    end
    if (i_done && (pend_full || !act_free)) begin
      pend <= i_sums;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      act_valid <= 1'b0;
      pend_full <= 1'b0;
      row       <= 4'd0;
    end else begin
      if (act_free) begin
        act_valid <= pend_full || i_done;
      end
      if (i_done && (pend_full || !act_free)) begin
        pend_full <= 1'b1;
      end else if (act_free) begin
        pend_full <= 1'b0;
      end
      if (xfer) begin
        row <= row + 4'd1;
      end
    end
  end

  // Round half up, then drop the low bits
  assign rounded        = act[row] + ROUND;
  assign o_coef         = rounded[ACC_W-1:OUT_SHIFT];
  assign o_coef_row     = row;
  assign o_coef_valid   = act_valid;
  assign o_pending_full = pend_full;

  a_hold_stalled: assert property (@(posedge clk) disable iff (i_reset)
    (o_coef_valid && !i_coef_ready) |=>
      (o_coef_valid && $stable(o_coef) && $stable(o_coef_row)));

endmodule

//--- rtl/dct32_odd_top.sv
// Odd half of the 32-point HEVC forward DCT, one sample in and one
// coefficient out per cycle
`timescale 1ns/1ps

module dct32_odd_top #(
  parameter int OUT_SHIFT = 4
) (
  input  logic                                        clk,
  input  logic                                        i_reset,
  input  logic signed [dct_odd_pkg::SAMPLE_W-1:0]       i_sample,
  input  logic                                        i_valid,
  output logic                                        o_ready,
  output logic signed [dct_odd_pkg::ACC_W-OUT_SHIFT-1:0] o_coef,
  output logic [3:0]                                  o_coef_row,
  output logic                                        o_coef_valid,
  input  logic                                        i_coef_ready
);
  import dct_odd_pkg::*;

  logic                     accept;
  logic [3:0]               pos;
  logic                     last;
  logic                     done;
  logic                     pending_full;
  logic signed [ACC_W-1:0]  sums [NUM_ROWS];
  logic signed [PROD_W-1:0] p4, p13, p22, p31, p38, p46, p54, p61;
  logic signed [PROD_W-1:0] p67, p73, p78, p82, p85, p88, p90;

  odd_sample_sequencer odd_sample_sequencer_inst (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_valid        (i_valid),
    .o_ready        (o_ready),
    .i_pending_full (pending_full),
    .o_accept       (accept),
    .o_pos          (pos),
    .o_last         (last)
  );

  spiral_16 spiral_16_inst (
    .i_data    (i_sample),
    .o_data_4  (p4),
    .o_data_13 (p13),
    .o_data_22 (p22),
    .o_data_31 (p31),
    .o_data_38 (p38),
    .o_data_46 (p46),
    .o_data_54 (p54),
    .o_data_61 (p61),
    .o_data_67 (p67),
    .o_data_73 (p73),
    .o_data_78 (p78),
    .o_data_82 (p82),
    .o_data_85 (p85),
    .o_data_88 (p88),
    .o_data_90 (p90)
  );

  odd_mac_bank odd_mac_bank_inst (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_accept  (accept),
    .i_pos     (pos),
    .i_last    (last),
    .i_prod_4  (p4),
    .i_prod_13 (p13),
    .i_prod_22 (p22),
    .i_prod_31 (p31),
    .i_prod_38 (p38),
    .i_prod_46 (p46),
    .i_prod_54 (p54),
    .i_prod_61 (p61),
    .i_prod_67 (p67),
    .i_prod_73 (p73),
    .i_prod_78 (p78),
    .i_prod_82 (p82),
    .i_prod_85 (p85),
    .i_prod_88 (p88),
    .i_prod_90 (p90),
    .o_done    (done),
    .o_sums    (sums)
  );

  coef_serializer #(
    .OUT_SHIFT (OUT_SHIFT)
  ) coef_serializer_inst (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_done         (done),
    .i_sums         (sums),
    .o_pending_full (pending_full),
    .o_coef         (o_coef),
    .o_coef_row     (o_coef_row),
    .o_coef_valid   (o_coef_valid),
    .i_coef_ready   (i_coef_ready)
  );

endmodule

//--- rtl/dct_odd_pkg.sv
// Shared widths, product ordering and coefficient selection for the
// odd half of the 32-point HEVC forward DCT
package dct_odd_pkg;

  localparam int SAMPLE_W = 17;
  localparam int PROD_W   = 24;
  localparam int ACC_W    = 28;
  localparam int NUM_ROWS = 16;
  localparam int NUM_PROD = 15;

  // Products ordered 4, 13, 22, 31, 38, 46, 54, 61, 67, 73, 78, 82, 85, 88, 90
  typedef logic [3:0] prod_idx_t;

  typedef struct packed {
    prod_idx_t idx;
    logic      neg;
  } coef_sel_t;

  // Magnitude slot to product index, slot m holds |c| for p = 2m+1
  localparam prod_idx_t SLOT_PROD [NUM_ROWS] = '{
    4'd14, 4'd14, 4'd13, 4'd12, 4'd11, 4'd10, 4'd9, 4'd8,
    4'd7,  4'd6,  4'd5,  4'd4,  4'd3,  4'd2,  4'd1, 4'd0
  };

  // Coefficient of odd row k (DCT row 2k+1) at sample n, folded into one quadrant
  function automatic coef_sel_t coef_select(input logic [3:0] row, input logic [3:0] pos);
    int        p;
    logic      neg;
    coef_sel_t sel;
    p   = ((2 * int'(row) + 1) * (2 * int'(pos) + 1)) % 128;
    neg = 1'b0;
    if (p > 64) begin
      p   = 128 - p;
    end
    if (p > 32) begin
      p   = 64 - p;
      neg = ~neg;
    end
    sel.idx = SLOT_PROD[(p - 1) / 2];
    sel.neg = neg;
    return sel;
  endfunction

endpackage

//--- rtl/odd_mac_bank.sv
// Product register and sixteen accumulators, one per odd output row,
// each adding its signed coefficient product for the current sample
`timescale 1ns/1ps

module odd_mac_bank (
  input  logic                                clk,
  input  logic                                i_reset,
  input  logic                                i_accept,
  input  logic [3:0]                          i_pos,
  input  logic                                i_last,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_4,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_13,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_22,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_31,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_38,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_46,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_54,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_61,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_67,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_73,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_78,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_82,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_85,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_88,
  input  logic signed [dct_odd_pkg::PROD_W-1:0] i_prod_90,
  output logic                                o_done,
  output logic signed [dct_odd_pkg::ACC_W-1:0]  o_sums [dct_odd_pkg::NUM_ROWS]
);
  import dct_odd_pkg::*;

  logic signed [PROD_W-1:0] prod_in [NUM_PROD];
  logic signed [PROD_W-1:0] prod_q  [NUM_PROD];
  logic [3:0]               pos_q;
  logic                     last_q;
  logic                     add_en;
  logic signed [ACC_W-1:0]  term [NUM_ROWS];
  logic signed [ACC_W-1:0]  acc  [NUM_ROWS];

  assign prod_in = '{i_prod_4, i_prod_13, i_prod_22, i_prod_31, i_prod_38,
                     i_prod_46, i_prod_54, i_prod_61, i_prod_67, i_prod_73,
                     i_prod_78, i_prod_82, i_prod_85, i_prod_88, i_prod_90};

  always_ff @(posedge clk) begin
    if (i_accept) begin
      prod_q <= prod_in;
      pos_q  <= i_pos;
      last_q <= i_last;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      add_en <= 1'b0;
      o_done <= 1'b0;
    end else begin
      add_en <= i_accept;
      o_done <= add_en && last_q;
    end
  end

  // Signed product each row picks for the registered sample position
  always_comb begin
    coef_sel_t               sel;
    logic signed [PROD_W-1:0] mag;
    for (int k = 0; k < NUM_ROWS; k++) begin
      sel     = coef_select(4'(k), pos_q);
      mag     = prod_q[sel.idx];
      term[k] = sel.neg ? -ACC_W'(mag) : ACC_W'(mag);
    end
  end

  always_ff @(posedge clk) begin
    if (add_en) begin
      for (int k = 0; k < NUM_ROWS; k++) begin
        // Position 0 starts a new block
        if (pos_q == 4'd0) begin
          acc[k] <= term[k];
        end else begin
          acc[k] <= acc[k] + term[k];
        end
      end
    end
  end

  assign o_sums = acc;

  // Blocks are at least 16 accepts apart
  a_done_single: assert property (@(posedge clk) disable iff (i_reset)
    o_done |=> !o_done);

endmodule

//--- rtl/odd_sample_sequencer.sv
// Input handshake and sample position counter, holds back the last sample
// of a block while the result path cannot take another block
`timescale 1ns/1ps

module odd_sample_sequencer (
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_valid,
  output logic       o_ready,
  input  logic       i_pending_full,
  output logic       o_accept,
  output logic [3:0] o_pos,
  output logic       o_last
);
  import dct_odd_pkg::*;

  logic [3:0] pos;
  logic [1:0] in_flight;
  logic       at_last;

  assign at_last = (pos == 4'(NUM_ROWS - 1));

  // Samples 0..14 always go through
  assign o_ready  = !(at_last && (i_pending_full || (in_flight != 2'b00)));
  assign o_accept = i_valid && o_ready;
  assign o_last   = o_accept && at_last;
  assign o_pos    = pos;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      pos       <= 4'd0;
      in_flight <= 2'b00;
    end else begin
      if (o_accept) begin
        pos <= pos + 4'd1;
      end
      // Block is in the product register, then in the accumulators
      in_flight <= {in_flight[0], o_last};
    end
  end

  // The pending bank stays free until the sums of a block let through arrive
  a_last_has_room: assert property (@(posedge clk) disable iff (i_reset)
    o_last |-> !i_pending_full [*3]);

endmodule

//--- rtl/spiral_16.sv
// Multiplierless constant network: one sample times the 15 odd DCT coefficients
`timescale 1ns/1ps

module spiral_16 (
  input  logic signed [dct_odd_pkg::SAMPLE_W-1:0] i_data,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_4,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_13,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_22,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_31,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_38,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_46,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_54,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_61,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_67,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_73,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_78,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_82,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_85,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_88,
  output logic signed [dct_odd_pkg::PROD_W-1:0]   o_data_90
);
  import dct_odd_pkg::*;

  localparam int W = PROD_W + 1;

  logic signed [W-1:0] x1, x4, x8, x9, x11, x13, x17, x19, x23, x27;
  logic signed [W-1:0] x31, x39, x41, x45, x61, x67, x73, x85;

  // Shared partial sums
  assign x1  = W'(i_data);
  assign x4  = x1 <<< 2;
  assign x8  = x1 <<< 3;
  assign x9  = x1 + x8;
  assign x11 = x9 + (x1 <<< 1);
  assign x13 = x9 + x4;
  assign x17 = x1 + (x1 <<< 4);
  assign x19 = x1 + (x9 <<< 1);
  assign x31 = (x1 <<< 5) - x1;
  assign x23 = x31 - x8;
  assign x27 = x31 - x4;
  assign x39 = x31 + x8;
  assign x41 = x9 + (x1 <<< 5);
  assign x45 = x9 + (x9 <<< 2);
  assign x61 = (x31 <<< 1) - x1;
  assign x67 = x31 + (x9 <<< 2);
  assign x73 = x9 + (x1 <<< 6);
  assign x85 = x17 + (x17 <<< 2);

  // Range fits in PROD_W, the top bit is only a sign copy
  assign o_data_4  = x4[PROD_W-1:0];
  assign o_data_13 = x13[PROD_W-1:0];
  assign o_data_22 = PROD_W'(x11 <<< 1);
  assign o_data_31 = x31[PROD_W-1:0];
  assign o_data_38 = PROD_W'(x19 <<< 1);
  assign o_data_46 = PROD_W'(x23 <<< 1);
  assign o_data_54 = PROD_W'(x27 <<< 1);
  assign o_data_61 = x61[PROD_W-1:0];
  assign o_data_67 = x67[PROD_W-1:0];
  assign o_data_73 = x73[PROD_W-1:0];
  assign o_data_78 = PROD_W'(x39 <<< 1);
  assign o_data_82 = PROD_W'(x41 <<< 1);
  assign o_data_85 = x85[PROD_W-1:0];
  assign o_data_88 = PROD_W'(x11 <<< 3);
  assign o_data_90 = PROD_W'(x45 <<< 1);

  default clocking cb @(posedge dct32_odd_top.clk);
  endclocking

  a_known_products: assert property (!$isunknown(i_data) |-> !$isunknown({
    o_data_4, o_data_13, o_data_22, o_data_31, o_data_38, o_data_46, o_data_54, o_data_61,
    o_data_67, o_data_73, o_data_78, o_data_82, o_data_85, o_data_88, o_data_90}));

endmodule

//--- verification/tb_dct32_odd.sv
// Testbench for the odd half of the 32-point HEVC forward DCT, random blocks
// checked against a matrix model with input gaps and output stalls
`timescale 1ns/1ps

module tb_dct32_odd;

  localparam int OUT_SHIFT        = 4;
  localparam int COEF_W           = 28 - OUT_SHIFT;
  localparam int CLK_NS           = 10;
  localparam int RESET_CYCLES     = 10;
  localparam int TOTAL_BLOCKS     = 1 + 3 + 40 + 20 + 20;
  localparam int CYCLES_PER_BLOCK = 200;

  // Odd rows 1, 3, ..., 31 of the HEVC 32-point matrix, first 16 columns
  localparam int ODD_MATRIX [16][16] = '{
    '{90,  90,  88,  85,  82,  78,  73,  67,  61,  54,  46,  38,  31,  22,  13,   4},
    '{90,  82,  67,  46,  22,  -4, -31, -54, -73, -85, -90, -88, -78, -61, -38, -13},
    '{88,  67,  31, -13, -54, -82, -90, -78, -46,  -4,  38,  73,  90,  85,  61,  22},
    '{85,  46, -13, -67, -90, -73, -22,  38,  82,  88,  54,  -4, -61, -90, -78, -31},
    '{82,  22, -54, -90, -61,  13,  78,  85,  31, -46, -90, -67,   4,  73,  88,  38},
    '{78,  -4, -82, -73,  13,  85,  67, -22, -88, -61,  31,  90,  54, -38, -90, -46},
    '{73, -31, -90, -22,  78,  67, -38, -90, -13,  82,  61, -46, -88,  -4,  85,  54},
    '{67, -54, -78,  38,  85, -22, -90,   4,  90,  13, -88, -31,  82,  46, -73, -61},
    '{61, -73, -46,  82,  31, -88, -13,  90,  -4, -90,  22,  85, -38, -78,  54,  67},
    '{54, -85,  -4,  88, -46, -61,  82,  13, -90,  38,  67, -78, -22,  90, -31, -73},
    '{46, -90,  38,  54, -90,  31,  61, -88,  22,  67, -85,  13,  73, -82,   4,  78},
    '{38, -88,  73,  -4, -67,  90, -46, -31,  85, -78,  13,  61, -90,  54,  22, -82},
    '{31, -78,  90, -61,   4,  54, -88,  82, -38, -22,  73, -90,  67, -13, -46,  85},
    '{22, -61,  85, -90,  73, -38,  -4,  46, -78,  90, -82,  54, -13, -31,  67, -88},
    '{13, -38,  61, -78,  88, -90,  85, -73,  54, -31,   4,  22, -46,  67, -82,  90},
    '{ 4, -13,  22, -31,  38, -46,  54, -61,  67, -73,  78, -82,  85, -88,  90, -90}
  };

  logic                     clk;
  logic                     i_reset;
  logic signed [16:0]       i_sample;
  logic                     i_valid;
  logic                     o_ready;
  logic signed [COEF_W-1:0] o_coef;
  logic [3:0]               o_coef_row;
  logic                     o_coef_valid;
  logic                     i_coef_ready;

  integer seed = 32'hea6c_9d16;
  int     block_buf [16];
  int     exp_q [$];
  int     row_q [$];
  string  cur_test = "reset";
  int     errors = 0;
  int     errors_start;
  int     rows_seen = 0;
  int     rows_start;
  int     blocks_sent;
  int     passed = 0;
  int     failed = 0;
  bit     gaps_on = 1'b0;
  bit     throttle_on = 1'b0;
  bit     ready_low_seen;
  bit     stall_prev = 1'b0;
  logic signed [COEF_W-1:0] held_coef;
  logic [3:0]               held_row;

  dct32_odd_top #(
    .OUT_SHIFT (OUT_SHIFT)
  ) dct32_odd_top_inst (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_sample     (i_sample),
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .o_coef       (o_coef),
    .o_coef_row   (o_coef_row),
    .o_coef_valid (o_coef_valid),
    .i_coef_ready (i_coef_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin : watchdog
    #((TOTAL_BLOCKS * CYCLES_PER_BLOCK + RESET_CYCLES) * CLK_NS);
    $display("Timeout in %s, outputs stopped arriving", cur_test);
    $display("Simulation failed");
    $finish;
  end

  // Sign extend 17 random bits
  function automatic int rand_sample();
    int r;
    r = $random(seed);
    return (r <<< 15) >>> 15;
  endfunction

  task automatic push_expected();
    int sum;
    for (int k = 0; k < 16; k++) begin
      sum = 0;
      for (int n = 0; n < 16; n++) begin
        sum += ODD_MATRIX[k][n] * block_buf[n];
      end
      exp_q.push_back((sum + (1 <<< (OUT_SHIFT - 1))) >>> OUT_SHIFT);
      row_q.push_back(k);
    end
  endtask

  // One block of samples, holding a sample while it is not taken
  task automatic send_block();
    int n;
    bit accepted;
    bit stalled;
    push_expected();
    blocks_sent++;
    n = 0;
    stalled = 1'b0;
    while (n < 16) begin
      if (!stalled) begin
        if (gaps_on && (($random(seed) & 3) == 0)) begin
          i_valid = 1'b0;
        end else begin
          i_valid  = 1'b1;
          i_sample = block_buf[n];
        end
      end
      @(negedge clk);
      accepted = i_valid && o_ready;
      @(posedge clk);
      #1;
      if (accepted) begin
        n++;
      end
      stalled = i_valid && !accepted;
    end
    i_valid = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    errors_start   = errors;
    rows_start     = rows_seen;
    blocks_sent    = 0;
    ready_low_seen = 1'b0;
  endtask

  task automatic end_test(input bit need_ready_low);
    int test_errors;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    #1;
    if (rows_seen - rows_start != 16 * blocks_sent) begin
      $display("%s received %0d rows for %0d blocks", cur_test, rows_seen - rows_start,
               blocks_sent);
      errors++;
    end
    if (need_ready_low && !ready_low_seen) begin
      $display("%s never saw o_ready low while the output was stalled", cur_test);
      errors++;
    end
    test_errors = errors - errors_start;
    if (test_errors == 0) begin
      passed++;
      $display("%s: passed", cur_test);
    end else begin
      failed++;
      $display("%s: failed with %0d errors", cur_test, test_errors);
    end
    gaps_on     = 1'b0;
    throttle_on = 1'b0;
  endtask

  // Output ready in long low stretches, random draws kept off the drive edge
  initial begin : ready_throttle
    int  stretch;
    bit  level;
    stretch = 0;
    level   = 1'b1;
    forever begin
      @(negedge clk);
      if (!throttle_on) begin
        level   = 1'b1;
        stretch = 0;
      end else if (stretch == 0) begin
        level   = !level;
        stretch = level ? 4 + ($random(seed) & 15) : 8 + ($random(seed) & 31);
      end else begin
        stretch--;
      end
      @(posedge clk);
      #1;
      i_coef_ready = level;
    end
  end

  initial begin : output_monitor
    int exp_val;
    int exp_row;
    forever begin
      @(negedge clk);
      if (!o_ready) begin
        ready_low_seen = 1'b1;
      end
      if (o_coef_valid && stall_prev) begin
        if (o_coef !== held_coef || o_coef_row !== held_row) begin
          $display("FAILED %s hold: expected %0d (row %0d), actual %0d (row %0d)",
                   cur_test, held_coef, held_row, o_coef, o_coef_row);
          errors++;
        end
      end
      if (o_coef_valid && i_coef_ready) begin
        rows_seen++;
        if (exp_q.size() == 0) begin
          $display("Row %0d came out in %s with no block outstanding", o_coef_row, cur_test);
          errors++;
        end else begin
          exp_val = exp_q.pop_front();
          exp_row = row_q.pop_front();
          if (o_coef_row !== exp_row[3:0]) begin
            $display("FAILED %s row index: expected %0d, actual %0d",
                     cur_test, exp_row, o_coef_row);
            errors++;
          end
          if (o_coef !== COEF_W'(exp_val)) begin
            $display("FAILED %s row %0d: expected %0d, actual %0d",
                     cur_test, exp_row, exp_val, o_coef);
            errors++;
          end
        end
      end
      if (o_coef_valid && !i_coef_ready) begin
        if (!stall_prev) begin
          held_coef = o_coef;
          held_row  = o_coef_row;
        end
        stall_prev = 1'b1;
      end else begin
        stall_prev = 1'b0;
      end
    end
  end

  initial begin : main
    i_reset      = 1'b1;
    i_sample     = '0;
    i_valid      = 1'b0;
    i_coef_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    i_reset = 1'b0;

    start_test("zero_block");
    for (int n = 0; n < 16; n++) block_buf[n] = 0;
    send_block();
    end_test(1'b0);

    start_test("extremes");
    for (int n = 0; n < 16; n++) block_buf[n] = 65535;
    send_block();
    for (int n = 0; n < 16; n++) block_buf[n] = -65536;
    send_block();
    for (int n = 0; n < 16; n++) block_buf[n] = (n % 2 == 0) ? 65535 : -65536;
    send_block();
    end_test(1'b0);

    start_test("random_blocks");
    for (int b = 0; b < 40; b++) begin
      for (int n = 0; n < 16; n++) block_buf[n] = rand_sample();
      send_block();
    end
    end_test(1'b0);

    start_test("input_gaps");
    gaps_on = 1'b1;
    for (int b = 0; b < 20; b++) begin
      for (int n = 0; n < 16; n++) block_buf[n] = rand_sample();
      send_block();
    end
    end_test(1'b0);

    start_test("output_backpressure");
    throttle_on = 1'b1;
    for (int b = 0; b < 20; b++) begin
      for (int n = 0; n < 16; n++) block_buf[n] = rand_sample();
      send_block();
    end
    end_test(1'b1);

    $display("Tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
rtl/dct_odd_pkg.sv
rtl/spiral_16.sv
rtl/odd_sample_sequencer.sv
rtl/odd_mac_bank.sv
rtl/coef_serializer.sv
rtl/dct32_odd_top.sv
verification/tb_dct32_odd.sv
